//--- hw/bus_slave_pkg.sv
/* shared widths, field types, request structs and state encodings for the
   serial bus slave; imported by every RTL block and by the testbench */
package bus_slave_pkg;

	// serial bus field widths
	localparam int ADDR_WIDTH = 12;
	localparam int DATA_WIDTH = 8;

	// bytes behind the offset field
	localparam int MEM_DEPTH = 256;

	// bus address, split as {slave number, byte offset}
	typedef logic [ADDR_WIDTH-1:0] addr_t;
	typedef logic [DATA_WIDTH-1:0] data_t;
	typedef logic [3:0] slave_id_t;
	typedef logic [7:0] offset_t;

	// number this slave answers to
	localparam slave_id_t SLAVE_ID = 4'h5;

	// request as it comes off the serial lines, 22 bits
	typedef struct packed {
		addr_t address;
		data_t data;
		logic  read;
		logic  write;
	} bus_req_t;

	// request after slave decode, 18 bits
	typedef struct packed {
		offset_t offset;
		data_t   data;
		logic    read;
		logic    write;
	} mem_req_t;

	// receive side fsm
	typedef enum logic [1:0] {
		RX_IDLE,
		RX_RECEIVE,
		RX_WAIT_DONE
	} rx_state_t;

	// response side fsm
	typedef enum logic {
		TX_IDLE,
		TX_SEND
	} tx_state_t;

endpackage

//--- hw/slave_in_port.sv
`timescale 1ns/1ps

/* receive port of the bus slave that shifts in address and data after the
   valid/ready handshake and keeps slave_ready low until txn_done */
module slave_in_port (
	input  logic                    clk,
	input  logic                    reset,
	input  logic                    master_valid,
	input  logic                    read_en,
	input  logic                    write_en,
	input  logic                    rx_address,
	input  logic                    rx_data,
	input  logic                    txn_done,
	output logic                    slave_ready,
	output bus_slave_pkg::bus_req_t bus_req,
	output logic                    rx_done
);
	import bus_slave_pkg::*;

	// one counter serves both serial lines
	rx_state_t  state;
	logic [3:0] bit_cnt;
	logic       handshake;
	logic       last_addr_bit;
	logic       data_bit;

	// ready only while idle, so it drops the cycle after a handshake
	assign slave_ready = (state == RX_IDLE);
	assign handshake = master_valid & slave_ready;

	// address runs 12 bits and data only the first 8
	assign last_addr_bit = (bit_cnt == 4'(ADDR_WIDTH - 1));
	assign data_bit = (bit_cnt < 4'(DATA_WIDTH));

	// control path
	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			state <= RX_IDLE;
			bit_cnt <= '0;
			rx_done <= 1'b0;
		end
		else
		begin
			// rx_done defaults low and is set for one cycle below
			rx_done <= 1'b0;
			case (state)
				RX_IDLE:
				begin
					// bit 0 is taken in the handshake cycle itself
					if (handshake)
					begin
						state <= RX_RECEIVE;
						bit_cnt <= 4'd1;
					end
				end
				RX_RECEIVE:
				begin
					if (last_addr_bit)
					begin
						// address bit 11 lands now and the request is complete in T12
						state <= RX_WAIT_DONE;
						bit_cnt <= '0;
						rx_done <= 1'b1;
					end
					else
					begin
						bit_cnt <= bit_cnt + 4'd1;
					end
				end
				RX_WAIT_DONE:
				begin
					// hold off the master until write, miss or response ends
					if (txn_done)
					begin
						state <= RX_IDLE;
					end
				end
				default:
				begin
					state <= RX_IDLE;
					bit_cnt <= '0;
				end
			endcase
		end
	end

	// request register filled lsb first on both lines
	always_ff @(posedge clk)
	begin
		if (handshake)
		begin
			bus_req.address[0] <= rx_address;
			bus_req.data[0] <= rx_data;
			bus_req.read <= read_en;
			bus_req.write <= write_en;
		end
		else if (state == RX_RECEIVE)
		begin
			bus_req.address[bit_cnt] <= rx_address;
			// data line ignored after bit 7
			if (data_bit)
			begin
				bus_req.data[bit_cnt[2:0]] <= rx_data;
			end
		end
	end

	// master must pick exactly one direction per transfer
	assert property (@(posedge clk) disable iff (reset)
		handshake |-> $onehot({read_en, write_en}));

	// rx_done is a single-cycle strobe
	assert property (@(posedge clk) disable iff (reset)
		rx_done |=> !rx_done);

endmodule

//--- hw/slave_request_decode.sv
`timescale 1ns/1ps

/* request decode that splits the bus address into slave number and offset,
   forwards hits to the memory and flags foreign slave numbers */
module slave_request_decode (
	input  logic                    clk,
	input  logic                    reset,
	input  bus_slave_pkg::bus_req_t bus_req,
	input  logic                    rx_done,
	output bus_slave_pkg::mem_req_t mem_req,
	output logic                    mem_strobe,
	output logic                    addr_error
);
	import bus_slave_pkg::*;

	slave_id_t req_id;
	offset_t   req_offset;
	logic      hit;

	// top bits pick the slave and low bits the byte
	assign req_id = bus_req.address[ADDR_WIDTH-1 -: $bits(slave_id_t)];
	assign req_offset = bus_req.address[$bits(offset_t)-1:0];
	assign hit = (req_id == SLAVE_ID);

	// strobes high in T13
	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			mem_strobe <= 1'b0;
			addr_error <= 1'b0;
		end
		else
		begin
			mem_strobe <= rx_done & hit;
			// a miss also ends the transfer at the in port
			addr_error <= rx_done & ~hit;
		end
	end

	// memory request only updated on a hit
	always_ff @(posedge clk)
	begin
		if (rx_done && hit)
		begin
			mem_req.offset <= req_offset;
			mem_req.data <= bus_req.data;
			mem_req.read <= bus_req.read;
			mem_req.write <= bus_req.write;
		end
	end

	// never a hit and a miss together
	assert property (@(posedge clk) disable iff (reset)
		!(mem_strobe && addr_error));

endmodule

//--- hw/slave_memory.sv
`timescale 1ns/1ps

/* byte storage behind the slave that writes on a strobed write request and
   registers a byte on a strobed read, and follows each with a completion strobe */
module slave_memory (
	input  logic                    clk,
	input  logic                    reset,
	input  bus_slave_pkg::mem_req_t mem_req,
	input  logic                    mem_strobe,
	output bus_slave_pkg::data_t    rd_data,
	output logic                    rd_strobe,
	output logic                    write_done
);
	import bus_slave_pkg::*;

	// contents undefined until written
	data_t mem [MEM_DEPTH];

	logic wr_req;
	logic rd_req;

	assign wr_req = mem_strobe & mem_req.write;
	assign rd_req = mem_strobe & mem_req.read;

	// completion strobes one cycle after the request in T14
	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			rd_strobe <= 1'b0;
			write_done <= 1'b0;
		end
		else
		begin
			rd_strobe <= rd_req;
			write_done <= wr_req;
		end
	end

	// write takes effect at the end of T13
	always_ff @(posedge clk)
	begin
		if (wr_req)
		begin
			mem[mem_req.offset] <= mem_req.data;
		end
	end

	// read data valid together with rd_strobe
	always_ff @(posedge clk)
	begin
		if (rd_req)
		begin
			rd_data <= mem[mem_req.offset];
		end
	end

	// direction carried through from the handshake stays one-hot
	assert property (@(posedge clk) disable iff (reset)
		mem_strobe |-> $onehot({mem_req.read, mem_req.write}));

endmodule

//--- hw/slave_out_port.sv
`timescale 1ns/1ps

/* response port that shifts a read byte back to the master lsb first while
   tx_valid is high and flags the last bit with tx_done */
module slave_out_port (
	input  logic                 clk,
	input  logic                 reset,
	input  bus_slave_pkg::data_t rd_data,
	input  logic                 rd_strobe,
	output logic                 tx_data,
	output logic                 tx_valid,
	output logic                 tx_done
);
	import bus_slave_pkg::*;

	tx_state_t  state;
	logic [2:0] bit_cnt;
	data_t      shift_q;

	// valid for the whole byte from T15 to T22
	assign tx_valid = (state == TX_SEND);
	// done rides on the last bit
	assign tx_done = tx_valid && (bit_cnt == 3'(DATA_WIDTH - 1));
	// line held low between responses
	assign tx_data = tx_valid & shift_q[0];

	// control path
	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			state <= TX_IDLE;
			bit_cnt <= '0;
		end
		else
		begin
			case (state)
				TX_IDLE:
				begin
					bit_cnt <= '0;
					if (rd_strobe)
					begin
						state <= TX_SEND;
					end
				end
				TX_SEND:
				begin
					if (tx_done)
					begin
						state <= TX_IDLE;
						bit_cnt <= '0;
					end
					else
					begin
						bit_cnt <= bit_cnt + 3'd1;
					end
				end
				default:
				begin
					state <= TX_IDLE;
					bit_cnt <= '0;
				end
			endcase
		end
	end

	// shift register loaded from memory and shifted right per bit
	always_ff @(posedge clk)
	begin
		if (rd_strobe)
		begin
			shift_q <= rd_data;
		end
		else if (tx_valid)
		begin
			shift_q <= {1'b0, shift_q[DATA_WIDTH-1:1]};
		end
	end

	// memory must not hand over a byte mid-response
	assert property (@(posedge clk) disable iff (reset)
		rd_strobe |-> (state == TX_IDLE));

endmodule

//--- hw/bus_slave_top.sv
`timescale 1ns/1ps

/* serial bus slave top: in port, decode, memory and out port in a chain,
   with the transfer-end OR fed back to the in port */
module bus_slave_top (
	input  logic clk,
	input  logic reset,
	input  logic master_valid,
	input  logic read_en,
	input  logic write_en,
	input  logic rx_address,
	input  logic rx_data,
	output logic slave_ready,
	output logic tx_data,
	output logic tx_valid,
	output logic addr_error
);
	import bus_slave_pkg::*;

	bus_req_t bus_req;
	logic     rx_done;
	mem_req_t mem_req;
	logic     mem_strobe;
	data_t    rd_data;
	logic     rd_strobe;
	logic     write_done;
	logic     tx_done;
	logic     txn_done;

	// write, miss or end of response closes the transfer
	assign txn_done = write_done | addr_error | tx_done;

	// serial receive
	slave_in_port u_in_port (
		.clk          (clk),
		.reset        (reset),
		.master_valid (master_valid),
		.read_en      (read_en),
		.write_en     (write_en),
		.rx_address   (rx_address),
		.rx_data      (rx_data),
		.txn_done     (txn_done),
		.slave_ready  (slave_ready),
		.bus_req      (bus_req),
		.rx_done      (rx_done)
	);

	// slave number check
	slave_request_decode u_decode (
		.clk        (clk),
		.reset      (reset),
		.bus_req    (bus_req),
		.rx_done    (rx_done),
		.mem_req    (mem_req),
		.mem_strobe (mem_strobe),
		.addr_error (addr_error)
	);

	// byte storage
	slave_memory u_memory (
		.clk        (clk),
		.reset      (reset),
		.mem_req    (mem_req),
		.mem_strobe (mem_strobe),
		.rd_data    (rd_data),
		.rd_strobe  (rd_strobe),
		.write_done (write_done)
	);

	// serial response
	slave_out_port u_out_port (
		.clk       (clk),
		.reset     (reset),
		.rd_data   (rd_data),
		.rd_strobe (rd_strobe),
		.tx_data   (tx_data),
		.tx_valid  (tx_valid),
		.tx_done   (tx_done)
	);

endmodule

//--- tb/bus_slave_tb.sv
`timescale 1ns/1ps

/* testbench for the serial bus slave that runs a table of directed and random transfers
   through a serial master model and checks them against a reference memory */
module bus_slave_tb;
	import bus_slave_pkg::*;

	localparam int HALF_PERIOD = 20;
	localparam int RESET_CYCLES = 5;
	localparam int READY_TIMEOUT = 64;
	localparam int NUM_RANDOM = 40;
	localparam logic [16:0] LFSR_SEED = 17'd67627;
	// observation windows after the handshake reach past the last expected event
	localparam int RESP_LAST = 24;
	localparam int ERR_LAST = 16;

	// one table row with direction, address, data and whether decode should miss
	typedef struct {
		string name;
		logic  is_read;
		logic  expect_miss;
		addr_t address;
		data_t data;
	} entry_t;

	logic clk;
	logic reset;
	logic master_valid;
	logic read_en;
	logic write_en;
	logic rx_address;
	logic rx_data;
	logic slave_ready;
	logic tx_data;
	logic tx_valid;
	logic addr_error;

	entry_t      stim_q[$];
	data_t       ref_mem [MEM_DEPTH];
	logic [16:0] lfsr_state;

	bus_slave_top UUT (
		.clk          (clk),
		.reset        (reset),
		.master_valid (master_valid),
		.read_en      (read_en),
		.write_en     (write_en),
		.rx_address   (rx_address),
		.rx_data      (rx_data),
		.slave_ready  (slave_ready),
		.tx_data      (tx_data),
		.tx_valid     (tx_valid),
		.addr_error   (addr_error)
	);

	always #(HALF_PERIOD) clk = ~clk;

	task automatic stop_on_failure();
		$display("Errors found");
		$fatal(1, "simulation stopped at first failure");
	endtask

	task automatic check_data(input string name, input data_t expected, input data_t actual);
		if (expected !== actual)
		begin
			$display("ERROR %s read byte: expected %h, actual %h", name, expected, actual);
			stop_on_failure();
		end
	endtask

	task automatic check_error(input string name, input int t, input logic expected,
			input logic actual);
		if (expected !== actual)
		begin
			$display("ERROR %s addr_error in T%0d: expected %b, actual %b",
				name, t, expected, actual);
			stop_on_failure();
		end
	endtask

	task automatic check_ready(input string name, input int t, input logic expected,
			input logic actual);
		if (expected !== actual)
		begin
			$display("ERROR %s slave_ready in T%0d: expected %b, actual %b",
				name, t, expected, actual);
			stop_on_failure();
		end
	endtask

	task automatic check_valid(input string name, input int t, input logic expected,
			input logic actual);
		if (expected !== actual)
		begin
			$display("ERROR %s tx_valid in T%0d: expected %b, actual %b",
				name, t, expected, actual);
			stop_on_failure();
		end
	endtask

	// fibonacci lfsr with taps x^17 + x^14 + 1
	function automatic logic [16:0] lfsr_next(input logic [16:0] state);
		return {state[15:0], state[16] ^ state[13]};
	endfunction

	// one lfsr step per bit taken
	task automatic take_bits(input int count, output logic [15:0] value);
		int k;
		value = '0;
		for (k = 0; k < count; k++)
		begin
			lfsr_state = lfsr_next(lfsr_state);
			value = {value[14:0], lfsr_state[0]};
		end
	endtask

	function automatic void add_entry(input string name, input logic is_read,
			input logic expect_miss, input addr_t address, input data_t data);
		entry_t e;
		e.name = name;
		e.is_read = is_read;
		e.expect_miss = expect_miss;
		e.address = address;
		e.data = data;
		stim_q.push_back(e);
	endfunction

	task automatic add_random_entries();
		logic        planned [MEM_DEPTH];
		logic [15:0] bits;
		logic        is_read;
		offset_t     offset;
		data_t       data;
		int          n;
		foreach (planned[i])
			planned[i] = 1'b0;
		// bytes already written by the directed rows
		foreach (stim_q[i])
			if (!stim_q[i].is_read && !stim_q[i].expect_miss)
				planned[stim_q[i].address[7:0]] = 1'b1;
		for (n = 0; n < NUM_RANDOM; n++)
		begin
			take_bits(1, bits);
			is_read = bits[0];
			// small window so reads revisit written bytes
			take_bits(4, bits);
			offset = {4'h4, bits[3:0]};
			take_bits(8, bits);
			data = bits[7:0];
			// nothing to read back yet, so write instead
			if (is_read && !planned[offset])
				is_read = 1'b0;
			if (!is_read)
				planned[offset] = 1'b1;
			add_entry($sformatf("random_%0d", n), is_read, 1'b0, {SLAVE_ID, offset}, data);
		end
	endtask

	task automatic wait_ready(input string name);
		int waited;
		waited = 0;
		@(negedge clk);
		while (!slave_ready && waited < READY_TIMEOUT)
		begin
			@(negedge clk);
			waited++;
		end
		if (!slave_ready)
		begin
			$display("Timed out waiting for slave_ready before test %s.", name);
			stop_on_failure();
		end
	endtask

	// bits 1 to 11 since bit 0 is already on the lines for the handshake
	task automatic drive_serial(input addr_t address, input data_t data);
		int i;
		for (i = 1; i < ADDR_WIDTH; i++)
		begin
			@(posedge clk);
			if (i == 1)
			begin
				master_valid <= 1'b0;
				read_en <= 1'b0;
				write_en <= 1'b0;
			end
			rx_address <= address[i];
			rx_data <= (i < DATA_WIDTH) ? data[i] : 1'b0;
		end
		@(posedge clk);
		rx_address <= 1'b0;
		rx_data <= 1'b0;
	endtask

	// ready high in T0 and low until the release cycle
	task automatic track_ready(input string name, input int release_at);
		int t;
		for (t = 0; t <= release_at; t++)
		begin
			@(negedge clk);
			check_ready(name, t, (t == 0) || (t == release_at), slave_ready);
		end
	endtask

	// tx_valid only in T15..T22 of a read hit with the byte lsb first
	task automatic capture_response(input string name, input logic expect_resp,
			output data_t rx_byte);
		int t;
		int nbits;
		nbits = 0;
		rx_byte = '0;
		for (t = 0; t <= RESP_LAST; t++)
		begin
			@(negedge clk);
			check_valid(name, t, expect_resp && t >= 15 && t <= 22, tx_valid);
			if (tx_valid && nbits < DATA_WIDTH)
			begin
				rx_byte[nbits] = tx_data;
				nbits++;
			end
		end
	endtask

	// a miss pulses addr_error in T13 only
	task automatic watch_error(input string name, input logic expect_miss);
		int t;
		for (t = 0; t <= ERR_LAST; t++)
		begin
			@(negedge clk);
			check_error(name, t, expect_miss && t == 13, addr_error);
		end
	endtask

	task automatic run_entry(input entry_t e);
		data_t rx_byte;
		int    release_at;
		release_at = e.expect_miss ? 14 : (e.is_read ? 23 : 15);
		wait_ready(e.name);
		// next rising edge is the handshake cycle T0
		@(posedge clk);
		master_valid <= 1'b1;
		read_en <= e.is_read;
		write_en <= !e.is_read;
		rx_address <= e.address[0];
		rx_data <= e.data[0];
		fork
			drive_serial(e.address, e.data);
			track_ready(e.name, release_at);
			capture_response(e.name, e.is_read && !e.expect_miss, rx_byte);
			watch_error(e.name, e.expect_miss);
		join
		if (!e.expect_miss)
		begin
			if (e.is_read)
				check_data(e.name, ref_mem[e.address[7:0]], rx_byte);
			else
				ref_mem[e.address[7:0]] = e.data;
		end
	endtask

	initial
	begin
		clk = 1'b0;
		reset = 1'b1;
		master_valid = 1'b0;
		read_en = 1'b0;
		write_en = 1'b0;
		rx_address = 1'b0;
		rx_data = 1'b0;
		lfsr_state = LFSR_SEED;
		// directed rows write and read back, then try foreign slave numbers
		add_entry("wr_off_00", 1'b0, 1'b0, 12'h500, 8'hA5);
		add_entry("wr_off_3c", 1'b0, 1'b0, 12'h53C, 8'h5A);
		add_entry("wr_off_80", 1'b0, 1'b0, 12'h580, 8'h80);
		add_entry("wr_off_ff", 1'b0, 1'b0, 12'h5FF, 8'h01);
		add_entry("rd_off_00", 1'b1, 1'b0, 12'h500, 8'h00);
		add_entry("rd_off_3c", 1'b1, 1'b0, 12'h53C, 8'h00);
		add_entry("rd_off_80", 1'b1, 1'b0, 12'h580, 8'h00);
		add_entry("rd_off_ff", 1'b1, 1'b0, 12'h5FF, 8'h00);
		add_entry("miss_wr_3c", 1'b0, 1'b1, 12'h33C, 8'hC3);
		add_entry("miss_rd_00", 1'b1, 1'b1, 12'hA00, 8'h00);
		add_entry("miss_wr_ff", 1'b0, 1'b1, 12'h4FF, 8'h77);
		add_entry("recheck_3c", 1'b1, 1'b0, 12'h53C, 8'h00);
		add_entry("recheck_ff", 1'b1, 1'b0, 12'h5FF, 8'h00);
		add_random_entries();
		repeat (RESET_CYCLES) @(posedge clk);
		reset <= 1'b0;
		@(negedge clk);
		check_ready("after_reset", 0, 1'b1, slave_ready);
		check_valid("after_reset", 0, 1'b0, tx_valid);
		check_error("after_reset", 0, 1'b0, addr_error);
		foreach (stim_q[i])
			run_entry(stim_q[i]);
		$display("No errors");
		$finish;
	end

endmodule

//--- verilog.f
hw/bus_slave_pkg.sv
hw/slave_in_port.sv
hw/slave_request_decode.sv
hw/slave_memory.sv
hw/slave_out_port.sv
hw/bus_slave_top.sv
tb/bus_slave_tb.sv

//--- Bender.yml
package:
  name: bus_slave

# rtl sources in compile order, package first
sources:
  - files:
      - hw/bus_slave_pkg.sv
      - hw/slave_in_port.sv
      - hw/slave_request_decode.sv
      - hw/slave_memory.sv
      - hw/slave_out_port.sv
      - hw/bus_slave_top.sv

  # testbench, top module bus_slave_tb
  - target: test
    files:
      - tb/bus_slave_tb.sv

# simulation top modules
# bus_slave_tb drives bus_slave_top as UUT
# file order matches verilog.f
